//--- design/cpu_pkg.sv
package cpu_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int num_regs   = 32;
   localparam int imm_w      = 16;
   localparam int op_w       = 6;

   // Depth of the carry-lookahead tree over xlen bits
   localparam int lac_levels = $clog2(xlen);

   // Primary opcodes
   localparam logic [op_w-1:0] op_rtype = 6'd0;
   localparam logic [op_w-1:0] op_xori  = 6'd1;
   localparam logic [op_w-1:0] op_subi  = 6'd2;
   localparam logic [op_w-1:0] op_addi  = 6'd3;
   localparam logic [op_w-1:0] op_ori   = 6'd12;
   localparam logic [op_w-1:0] op_andi  = 6'd15;
   localparam logic [op_w-1:0] op_lw    = 6'd30;
   localparam logic [op_w-1:0] op_sw    = 6'd31;

   // R-type function codes
   localparam logic [op_w-1:0] fn_xor = 6'd1;
   localparam logic [op_w-1:0] fn_sub = 6'd2;
   localparam logic [op_w-1:0] fn_add = 6'd3;
   localparam logic [op_w-1:0] fn_or  = 6'd4;
   localparam logic [op_w-1:0] fn_and = 6'd7;

   typedef logic [xlen-1:0]       word_t;
   typedef logic [reg_addr_w-1:0] reg_idx_t;

   // Upper three bits select the cell function, bit 0 is the carry-in
   typedef enum logic [3:0] {
      alu_xor = 4'b0000,
      alu_sub = 4'b0111,
      alu_add = 4'b0100,
      alu_or  = 4'b1000,
      alu_and = 4'b1100
   } alu_op_t;

   typedef struct packed {
      logic [op_w-1:0] opcode;
      reg_idx_t        rs;
      reg_idx_t        rt;
      reg_idx_t        rd;
      logic [4:0]      shamt;
      logic [op_w-1:0] funct;
   } rtype_t;

   typedef struct packed {
      logic [op_w-1:0]  opcode;
      reg_idx_t         rs;
      reg_idx_t         rt;
      logic [imm_w-1:0] imm;
   } itype_t;

   typedef union packed {
      rtype_t r;
      itype_t i;
   } instr_t;

   // Start index of one level inside the flattened lookahead tree vectors
   function automatic int lac_base(int level);
      return 2 * xlen - ((2 * xlen) >> level);
   endfunction

endpackage

//--- design/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;
   cpu_pkg::word_t    a_val;
   cpu_pkg::word_t    b_val;
   cpu_pkg::word_t    imm_val;
   logic              use_imm;
   cpu_pkg::alu_op_t  alu_op;
   cpu_pkg::reg_idx_t dest;
   logic              we;
   logic              load;
   logic              store;

   modport src (
      output a_val, b_val, imm_val, use_imm, alu_op,
      output dest, we, load, store
   );

   modport dst (
      input a_val, b_val, imm_val, use_imm, alu_op,
      input dest, we, load, store
   );
endinterface

//--- design/ex_mem_if.sv
`timescale 1ns/1ps

interface ex_mem_if;
   cpu_pkg::word_t    result;
   cpu_pkg::word_t    store_data;
   cpu_pkg::reg_idx_t dest;
   logic              we;
   logic              load;
   logic              store;

   modport src (
      output result, store_data, dest, we, load, store
   );

   modport dst (
      input result, store_data, dest, we, load, store
   );
endinterface

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
   input  cpu_pkg::word_t   a,
   input  cpu_pkg::word_t   b,
   input  cpu_pkg::alu_op_t op,
   output cpu_pkg::word_t   y
);
   logic [2:0] sel;
   logic       cin;

   // Flattened tree where level l starts at lac_base(l) and holds xlen >> l groups
   logic [cpu_pkg::lac_base(cpu_pkg::lac_levels)-1:0] g_tree;
   logic [cpu_pkg::lac_base(cpu_pkg::lac_levels)-1:0] p_tree;
   logic [cpu_pkg::lac_base(cpu_pkg::lac_levels):0]   c_tree;

   assign {sel, cin} = op;

   // Per-bit cells with b inverted for subtraction
   for (genvar i = 0; i < cpu_pkg::xlen; i++) begin : g_cell
      logic b_in;
      logic c_in;

      assign b_in        = b[i] ^ sel[0];
      assign g_tree[i]   = a[i] & b_in;
      assign p_tree[i]   = a[i] ^ b_in;
      assign c_in        = sel[1] & c_tree[i];
      assign y[i] = !sel[2]              ? (p_tree[i] ^ c_in) :
                    (sel[1:0] == 2'b00) ? (a[i] | b[i]) :
                    (sel[1:0] == 2'b10) ? (a[i] & b[i]) : 1'b0;
   end

   // Upward pass builds group generate and propagate from pairs of the level below
   for (genvar l = 1; l < cpu_pkg::lac_levels; l++) begin : g_gp_level
      for (genvar j = 0; j < (cpu_pkg::xlen >> l); j++) begin : g_gp
         assign g_tree[cpu_pkg::lac_base(l) + j] =
            g_tree[cpu_pkg::lac_base(l-1) + 2*j + 1] |
            (p_tree[cpu_pkg::lac_base(l-1) + 2*j + 1] & g_tree[cpu_pkg::lac_base(l-1) + 2*j]);
         assign p_tree[cpu_pkg::lac_base(l) + j] =
            p_tree[cpu_pkg::lac_base(l-1) + 2*j + 1] & p_tree[cpu_pkg::lac_base(l-1) + 2*j];
      end
   end

   // Root carry is the operation's carry-in
   assign c_tree[cpu_pkg::lac_base(cpu_pkg::lac_levels)] = cin;

   // Downward pass hands each node's carry on to its two children
   for (genvar l = 0; l < cpu_pkg::lac_levels; l++) begin : g_c_level
      for (genvar j = 0; j < (cpu_pkg::xlen >> (l + 1)); j++) begin : g_c
         assign c_tree[cpu_pkg::lac_base(l) + 2*j] = c_tree[cpu_pkg::lac_base(l+1) + j];
         assign c_tree[cpu_pkg::lac_base(l) + 2*j + 1] =
            g_tree[cpu_pkg::lac_base(l) + 2*j] |
            (p_tree[cpu_pkg::lac_base(l) + 2*j] & c_tree[cpu_pkg::lac_base(l+1) + j]);
      end
   end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file (
   input  logic              clk,
   input  logic              arst_n,
   input  cpu_pkg::reg_idx_t rs_idx,
   input  cpu_pkg::reg_idx_t rt_idx,
   input  logic              wb_we,
   input  cpu_pkg::reg_idx_t wb_dest,
   input  cpu_pkg::word_t    wb_data,
   output cpu_pkg::word_t    rs_val,
   output cpu_pkg::word_t    rt_val
);
   cpu_pkg::word_t regs [1:cpu_pkg::num_regs-1];

   // Write in the middle of the cycle so decode sees it before the next rising edge
   always_ff @(negedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < cpu_pkg::num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_we && (wb_dest != '0)) begin
         regs[wb_dest] <= wb_data;
      end
   end

   assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
   assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];

   // Read port shows a write before the next rising edge and register 0 stays zero
   a_write_visible: assert property (
      @(posedge clk) disable iff (!arst_n)
         (wb_we && (rs_idx == wb_dest)) |->
            (rs_val == ((wb_dest == '0) ? '0 : wb_data))
   );

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
   input  logic              clk,
   input  logic              arst_n,
   input  cpu_pkg::word_t    instr,
   input  cpu_pkg::word_t    rs_val,
   input  cpu_pkg::word_t    rt_val,
   output cpu_pkg::reg_idx_t rs_idx,
   output cpu_pkg::reg_idx_t rt_idx,
   id_ex_if.src              ex
);
   cpu_pkg::instr_t   if_id;
   cpu_pkg::alu_op_t  dec_op;
   cpu_pkg::word_t    dec_imm;
   cpu_pkg::reg_idx_t dec_dest;
   logic              dec_use_imm;
   logic              dec_we;
   logic              dec_load;
   logic              dec_store;

   // IF/ID register clears to an R-type word with funct 0 that decodes as a bubble
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         if_id <= '0;
      end else begin
         if_id <= instr;
      end
   end

   assign rs_idx = if_id.r.rs;
   assign rt_idx = if_id.r.rt;

   assign dec_imm = {{(cpu_pkg::xlen - cpu_pkg::imm_w){if_id.i.imm[cpu_pkg::imm_w-1]}},
                     if_id.i.imm};

   always_comb begin
      dec_op      = cpu_pkg::alu_add;
      dec_use_imm = 1'b0;
      dec_dest    = if_id.i.rt;
      dec_we      = 1'b0;
      dec_load    = 1'b0;
      dec_store   = 1'b0;
      if (if_id.r.opcode == cpu_pkg::op_rtype) begin
         dec_dest = if_id.r.rd;
         dec_we   = 1'b1;
         case (if_id.r.funct)
            cpu_pkg::fn_xor: dec_op = cpu_pkg::alu_xor;
            cpu_pkg::fn_sub: dec_op = cpu_pkg::alu_sub;
            cpu_pkg::fn_add: dec_op = cpu_pkg::alu_add;
            cpu_pkg::fn_or:  dec_op = cpu_pkg::alu_or;
            cpu_pkg::fn_and: dec_op = cpu_pkg::alu_and;
            default:         dec_we = 1'b0;
         endcase
      end else begin
         // Immediate forms and memory ops all take rt as destination
         dec_use_imm = 1'b1;
         dec_we      = 1'b1;
         case (if_id.i.opcode)
            cpu_pkg::op_xori: dec_op = cpu_pkg::alu_xor;
            cpu_pkg::op_subi: dec_op = cpu_pkg::alu_sub;
            cpu_pkg::op_addi: dec_op = cpu_pkg::alu_add;
            cpu_pkg::op_ori:  dec_op = cpu_pkg::alu_or;
            cpu_pkg::op_andi: dec_op = cpu_pkg::alu_and;
            cpu_pkg::op_lw:   dec_load = 1'b1;
            cpu_pkg::op_sw: begin
               dec_store = 1'b1;
               dec_we    = 1'b0;
            end
            default: dec_we = 1'b0;
         endcase
      end
   end

   // ID/EX control bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex.we    <= 1'b0;
         ex.load  <= 1'b0;
         ex.store <= 1'b0;
      end else begin
         ex.we    <= dec_we;
         ex.load  <= dec_load;
         ex.store <= dec_store;
      end
   end

   // ID/EX operands
   always_ff @(posedge clk) begin
      ex.a_val   <= rs_val;
      ex.b_val   <= rt_val;
      ex.imm_val <= dec_imm;
      ex.use_imm <= dec_use_imm;
      ex.alu_op  <= dec_op;
      ex.dest    <= dec_dest;
   end

   // A store reaching execute must neither load nor write back
   a_store_exclusive: assert property (
      @(posedge clk) disable iff (!arst_n)
         ex.store |-> (!ex.load && !ex.we)
   );

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
   input logic   clk,
   input logic   arst_n,
   id_ex_if.dst  id,
   ex_mem_if.src mem
);
   cpu_pkg::word_t op_b;
   cpu_pkg::word_t alu_y;

   assign op_b = id.use_imm ? id.imm_val : id.b_val;

   alu alu_i (
      .a  (id.a_val),
      .b  (op_b),
      .op (id.alu_op),
      .y  (alu_y)
   );

   // EX/MEM control bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem.we    <= 1'b0;
         mem.load  <= 1'b0;
         mem.store <= 1'b0;
      end else begin
         mem.we    <= id.we;
         mem.load  <= id.load;
         mem.store <= id.store;
      end
   end

   // Result doubles as the data address for lw and sw
   always_ff @(posedge clk) begin
      mem.result     <= alu_y;
      mem.store_data <= id.b_val;
      mem.dest       <= id.dest;
   end

endmodule

//--- design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
   input  logic              clk,
   input  logic              arst_n,
   input  cpu_pkg::word_t    load_data,
   ex_mem_if.dst             mem,
   output logic              wb_we,
   output cpu_pkg::reg_idx_t wb_dest,
   output cpu_pkg::word_t    wb_data
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_we <= 1'b0;
      end else begin
         wb_we <= mem.we;
      end
   end

   // Memory answers within the cycle, so load data is taken at the same edge
   always_ff @(posedge clk) begin
      wb_data <= mem.load ? load_data : mem.result;
      wb_dest <= mem.dest;
   end

   a_load_data_known: assert property (
      @(posedge clk) disable iff (!arst_n)
         mem.load |-> !$isunknown(load_data)
   );

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
   input  logic           clk,
   input  logic           arst_n,
   input  cpu_pkg::word_t instr,
   input  cpu_pkg::word_t load_data,
   output cpu_pkg::word_t data_addr,
   output cpu_pkg::word_t store_data,
   output logic           load_en,
   output logic           store_en
);
   cpu_pkg::reg_idx_t rs_idx;
   cpu_pkg::reg_idx_t rt_idx;
   cpu_pkg::word_t    rs_val;
   cpu_pkg::word_t    rt_val;
   logic              wb_we;
   cpu_pkg::reg_idx_t wb_dest;
   cpu_pkg::word_t    wb_data;

   id_ex_if  id_ex_bus ();
   ex_mem_if ex_mem_bus ();

   decode_stage decode_stage_i (
      .clk    (clk),
      .arst_n (arst_n),
      .instr  (instr),
      .rs_val (rs_val),
      .rt_val (rt_val),
      .rs_idx (rs_idx),
      .rt_idx (rt_idx),
      .ex     (id_ex_bus.src)
   );

   register_file register_file_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .rs_idx  (rs_idx),
      .rt_idx  (rt_idx),
      .wb_we   (wb_we),
      .wb_dest (wb_dest),
      .wb_data (wb_data),
      .rs_val  (rs_val),
      .rt_val  (rt_val)
   );

   execute_stage execute_stage_i (
      .clk    (clk),
      .arst_n (arst_n),
      .id     (id_ex_bus.dst),
      .mem    (ex_mem_bus.src)
   );

   mem_wb_stage mem_wb_stage_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .load_data (load_data),
      .mem       (ex_mem_bus.dst),
      .wb_we     (wb_we),
      .wb_dest   (wb_dest),
      .wb_data   (wb_data)
   );

   // Data memory side is driven straight from the EX/MEM register
   assign data_addr  = ex_mem_bus.result;
   assign store_data = ex_mem_bus.store_data;
   assign load_en    = ex_mem_bus.load;
   assign store_en   = ex_mem_bus.store;

endmodule

//--- tb/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Expected memory-side outputs of one instruction due three cycles after issue
typedef struct packed {
   logic [31:0]    tag;
   cpu_pkg::word_t addr;
   cpu_pkg::word_t sdata;
   logic           load;
   logic           store;
} expect_t;

cpu_pkg::word_t    ref_regs [0:cpu_pkg::num_regs-1] = '{default: '0};
cpu_pkg::word_t    ref_mem [0:255];
// Register writes of the last three instructions with the oldest first
logic              pend_we [0:2] = '{default: 1'b0};
cpu_pkg::reg_idx_t pend_dest [0:2] = '{default: '0};
cpu_pkg::word_t    pend_val [0:2] = '{default: '0};
expect_t           exp_q [$];

task automatic ref_execute(input cpu_pkg::word_t w, input int tag);
   logic              is_r;
   cpu_pkg::reg_idx_t rt;
   cpu_pkg::word_t    a;
   cpu_pkg::word_t    b;
   expect_t           e;
   // The write from three instructions back becomes visible now
   if (pend_we[0]) begin
      ref_regs[pend_dest[0]] = pend_val[0];
   end
   for (int i = 0; i < 2; i++) begin
      pend_we[i]   = pend_we[i+1];
      pend_dest[i] = pend_dest[i+1];
      pend_val[i]  = pend_val[i+1];
   end
   is_r = (w[31:26] == cpu_pkg::op_rtype);
   rt   = w[20:16];
   a    = ref_regs[w[25:21]];
   b    = is_r ? ref_regs[rt] : {{16{w[15]}}, w[15:0]};
   // Add covers add, addi, lw and sw
   case ({is_r, is_r ? w[5:0] : w[31:26]})
      {1'b1, cpu_pkg::fn_xor}, {1'b0, cpu_pkg::op_xori}: e.addr = a ^ b;
      {1'b1, cpu_pkg::fn_sub}, {1'b0, cpu_pkg::op_subi}: e.addr = a - b;
      {1'b1, cpu_pkg::fn_or},  {1'b0, cpu_pkg::op_ori}:  e.addr = a | b;
      {1'b1, cpu_pkg::fn_and}, {1'b0, cpu_pkg::op_andi}: e.addr = a & b;
      default: e.addr = a + b;
   endcase
   e.tag        = tag;
   e.sdata      = ref_regs[rt];
   e.load       = (w[31:26] == cpu_pkg::op_lw);
   e.store      = (w[31:26] == cpu_pkg::op_sw);
   pend_dest[2] = is_r ? w[15:11] : rt;
   pend_we[2]   = !e.store && (pend_dest[2] != 5'd0);
   pend_val[2]  = e.load ? ref_mem[e.addr[7:0]] : e.addr;
   if (e.store) begin
      ref_mem[e.addr[7:0]] = e.sdata;
   end
   exp_q.push_back(e);
endtask

`endif

//--- tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
   logic              clk;
   logic              arst_n;
   cpu_pkg::word_t    instr;
   cpu_pkg::word_t    load_data;
   cpu_pkg::word_t    data_addr;
   cpu_pkg::word_t    store_data;
   logic              load_en;
   logic              store_en;
   integer            seed;
   int                cycle_no;
   int                wait_cycles;
   cpu_pkg::word_t    next_instr;
   cpu_pkg::word_t    dmem [0:255];

   `include "cpu_ref_model.svh"

   cpu_top cpu_top_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .instr      (instr),
      .load_data  (load_data),
      .data_addr  (data_addr),
      .store_data (store_data),
      .load_en    (load_en),
      .store_en   (store_en)
   );

   // Data memory answers within the cycle
   assign load_data = dmem[data_addr[7:0]];

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic compare_word(input string name, input cpu_pkg::word_t exp,
                               input cpu_pkg::word_t act);
      assert (act === exp) else begin
         $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic random_instr(output cpu_pkg::word_t w);
      logic [31:0]       r;
      logic [71:0]       codes;
      logic [5:0]        code;
      int                kind;
      cpu_pkg::reg_idx_t rs;
      cpu_pkg::reg_idx_t rd;
      r     = $random(seed);
      codes = {cpu_pkg::op_sw, cpu_pkg::op_lw, cpu_pkg::op_andi, cpu_pkg::op_ori,
               cpu_pkg::op_addi, cpu_pkg::op_subi, cpu_pkg::op_xori, cpu_pkg::fn_and,
               cpu_pkg::fn_or, cpu_pkg::fn_add, cpu_pkg::fn_sub, cpu_pkg::fn_xor};
      kind  = int'(r[31:28]) % 12;
      code  = codes[kind*6 +: 6];
      // Registers 0 to 7 only, so dependent sequences show up often
      rs    = {2'b00, r[2:0]};
      rd    = {2'b00, r[5:3]};
      if (kind < 5) begin
         w = {cpu_pkg::op_rtype, rs, {2'b00, r[8:6]}, rd, r[13:9], code};
      end else begin
         w = {code, rs, rd, r[27:12]};
      end
   endtask

   // Memory-side outputs are stable at the falling edge
   always @(negedge clk) begin
      if (arst_n && exp_q.size() > 0 && exp_q[0].tag + 3 == cycle_no) begin
         compare_word("data_addr", exp_q[0].addr, data_addr);
         compare_word("load_en", {31'd0, exp_q[0].load}, {31'd0, load_en});
         compare_word("store_en", {31'd0, exp_q[0].store}, {31'd0, store_en});
         if (store_en) begin
            compare_word("store_data", exp_q[0].sdata, store_data);
            dmem[data_addr[7:0]] = store_data;
         end
         exp_q.delete(0);
      end else if (arst_n) begin
         compare_word("load_en", 32'd0, {31'd0, load_en});
         compare_word("store_en", 32'd0, {31'd0, store_en});
      end
   end

   initial begin
      seed      = 71238;
      arst_n    = 1'b0;
      instr     = '0;
      cycle_no  = 0;
      for (int i = 0; i < 256; i++) begin
         dmem[i]    = $random(seed);
         ref_mem[i] = dmem[i];
      end
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      // One instruction per cycle without gaps
      for (int n = 0; n < 400; n++) begin
         random_instr(next_instr);
         @(posedge clk);
         instr <= next_instr;
         cycle_no = cycle_no + 1;
         ref_execute(next_instr, cycle_no);
      end
      // Bubbles while the last results come out
      wait_cycles = 0;
      while (exp_q.size() > 0 && wait_cycles < 10) begin
         @(posedge clk);
         instr <= '0;
         cycle_no = cycle_no + 1;
         wait_cycles = wait_cycles + 1;
      end
      if (exp_q.size() > 0) begin
         $display("Timeout, results still missing after the pipeline drained");
         $display("Simulation FAILED");
         $fatal(1, "drain timeout");
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

//--- compile.f
design/cpu_pkg.sv
design/id_ex_if.sv
design/ex_mem_if.sv
design/alu.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_top.sv
+incdir+tb
tb/tb_cpu.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -j 0 --top-module tb_cpu -f compile.f \
   && ./obj_dir/Vtb_cpu | tee /dev/stderr | grep -q "Simulation PASSED" \
   && echo "run ok" \
   || { echo "run not ok"; exit 1; }
